// ==== logic/wr_settings.svh ====
`ifndef WR_SETTINGS_SVH
`define WR_SETTINGS_SVH

// datapath widths
`define WR_DATA_W           32
`define WR_SEL_W            16
`define WR_TSS_IMAGE_W      400

// descriptor types up to this one use the 286 task layout
`define WR_TSS16_MAX_TYPE   3

// eflags bit positions
`define WR_EF_CF            0
`define WR_EF_PF            2
`define WR_EF_AF            4
`define WR_EF_ZF            6
`define WR_EF_SF            7
`define WR_EF_OF            11

// bits a task load may write, bit 1 reads as one
`define WR_EF_WRITABLE      32'h0027_7FD5
`define WR_EF_FIXED_ONE     32'h0000_0002
`define WR_EF_RESET         32'h0000_0002

// task image field offsets, low bit of each field
`define WR_TSS32_EFLAGS_LO  368
`define WR_TSS32_EFLAGS_W   32
`define WR_TSS16_FLAGS_LO   368
`define WR_TSS16_FLAGS_W    16
`define WR_TSS_ES_LO        96
`define WR_TSS_CS_LO        80
`define WR_TSS_SS_LO        64
`define WR_TSS_DS_LO        48
`define WR_TSS32_FS_LO      32
`define WR_TSS32_GS_LO      16
`define WR_TSS32_LDTR_LO    0
`define WR_TSS16_LDTR_LO    32

`endif

// ==== logic/wr_pkg.sv ====
`include "wr_settings.svh"

package wr_pkg;

    // ------------------------------------------------------------
    // command and operation encodings
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        CMD_NONE      = 2'd0,
        CMD_ARITH     = 2'd1,
        CMD_TASK_LOAD = 2'd2
    } wr_cmd_e;

    // bit 3 marks a valid arith index, low bits are the ALU group
    typedef enum logic [3:0] {
        OP_LOGIC_MISC = 4'b0000,
        OP_ADD        = 4'b1000,
        OP_OR         = 4'b1001,
        OP_ADC        = 4'b1010,
        OP_SBB        = 4'b1011,
        OP_AND        = 4'b1100,
        OP_SUB        = 4'b1101,
        OP_XOR        = 4'b1110,
        OP_CMP        = 4'b1111
    } arith_op_e;

    typedef enum logic [1:0] {
        SIZE_8  = 2'd0,
        SIZE_16 = 2'd1,
        SIZE_32 = 2'd2
    } op_size_e;

    // ------------------------------------------------------------
    // signal groups
    // ------------------------------------------------------------

    typedef struct packed {
        logic [`WR_DATA_W-1:0] src;
        logic [`WR_DATA_W-1:0] dst;
        logic [`WR_DATA_W-1:0] result;
    } operands_t;

    // carry-outs of the full-width adder
    typedef struct packed {
        logic add_c;
        logic adc_c;
        logic sbb_c;
        logic sub_c;
    } alu_carries_t;

    typedef struct packed {
        logic of;
        logic sf;
        logic zf;
        logic af;
        logic pf;
        logic cf;
    } arith_flags_t;

    typedef struct packed {
        logic [`WR_SEL_W-1:0] es;
        logic [`WR_SEL_W-1:0] cs;
        logic [`WR_SEL_W-1:0] ss;
        logic [`WR_SEL_W-1:0] ds;
        logic [`WR_SEL_W-1:0] fs;
        logic [`WR_SEL_W-1:0] gs;
        logic [`WR_SEL_W-1:0] ldtr;
    } task_sels_t;

endpackage

// ==== logic/wr_flags_calc.sv ====
`timescale 1ns/1ps
`include "wr_settings.svh"

module wr_flags_calc (
    input  wr_pkg::arith_op_e    op,
    input  wr_pkg::op_size_e     size,
    input  wr_pkg::operands_t    opnds,
    input  wr_pkg::alu_carries_t carries,
    output wr_pkg::arith_flags_t flags
);

    logic                  logic_class;
    logic                  sub_class;
    logic [`WR_DATA_W-1:0] carry_vec;
    logic                  src_sign;
    logic                  dst_sign;
    logic                  res_sign;
    logic                  res_zero;
    logic                  cf_sized;
    logic                  cf_wide;
    logic                  of_sized;

    // ------------------------------------------------------------
    // operation class
    // ------------------------------------------------------------

    // shifts, bcd adjust and bit scans share the logic class
    assign logic_class = !op[3] || op == wr_pkg::OP_OR || op == wr_pkg::OP_AND ||
                         op == wr_pkg::OP_XOR;

    assign sub_class = op inside {wr_pkg::OP_SBB, wr_pkg::OP_SUB, wr_pkg::OP_CMP};

    // carry into each bit position
    assign carry_vec = opnds.src ^ opnds.dst ^ opnds.result;

    // full width carry is taken from the adder
    always_comb begin
        case (op)
            wr_pkg::OP_ADD: cf_wide = carries.add_c;
            wr_pkg::OP_ADC: cf_wide = carries.adc_c;
            wr_pkg::OP_SBB: cf_wide = carries.sbb_c;
            default:        cf_wide = carries.sub_c;
        endcase
    end

    // ------------------------------------------------------------
    // size dependent taps
    // ------------------------------------------------------------

    always_comb begin
        case (size)
            wr_pkg::SIZE_8: begin
                src_sign = opnds.src[7];
                dst_sign = opnds.dst[7];
                res_sign = opnds.result[7];
                res_zero = opnds.result[7:0] == 8'd0;
                cf_sized = carry_vec[8];
            end
            wr_pkg::SIZE_16: begin
                src_sign = opnds.src[15];
                dst_sign = opnds.dst[15];
                res_sign = opnds.result[15];
                res_zero = opnds.result[15:0] == 16'd0;
                cf_sized = carry_vec[16];
            end
            default: begin
                src_sign = opnds.src[`WR_DATA_W-1];
                dst_sign = opnds.dst[`WR_DATA_W-1];
                res_sign = opnds.result[`WR_DATA_W-1];
                res_zero = opnds.result == '0;
                cf_sized = cf_wide;
            end
        endcase
    end

    // signed overflow from the sign bits
    always_comb begin
        if (sub_class) begin
            of_sized = (src_sign != dst_sign) && (res_sign != dst_sign);
        end else begin
            of_sized = (src_sign == dst_sign) && (res_sign != src_sign);
        end
    end

    always_comb begin
        flags.sf = res_sign;
        flags.zf = res_zero;
        flags.pf = ~^opnds.result[7:0];
        flags.af = logic_class ? 1'b0 : carry_vec[4];
        flags.cf = logic_class ? 1'b0 : cf_sized;
        flags.of = logic_class ? 1'b0 : of_sized;
    end

    always_comb begin
        assert (size inside {wr_pkg::SIZE_8, wr_pkg::SIZE_16, wr_pkg::SIZE_32})
            else $error("wr_flags_calc: unknown operand size %0d", size);
    end

endmodule

// ==== logic/wr_task_unpack.sv ====
`timescale 1ns/1ps
`include "wr_settings.svh"

module wr_task_unpack (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       wr_ready,
    input  wr_pkg::wr_cmd_e            wr_cmd,
    input  logic [3:0]                 tss_type,
    input  logic [`WR_TSS_IMAGE_W-1:0] tss_image,
    output logic [`WR_DATA_W-1:0]      task_eflags,
    output logic                       task_load,
    output wr_pkg::task_sels_t         seg_sels,
    output logic                       task_done
);

    logic               is_tss16;
    wr_pkg::task_sels_t sels_next;

    // ------------------------------------------------------------
    // layout decode
    // ------------------------------------------------------------

    // 286 style descriptor types
    assign is_tss16 = tss_type <= `WR_TSS16_MAX_TYPE;

    assign task_load = wr_ready && (wr_cmd == wr_pkg::CMD_TASK_LOAD);

    // 16-bit image carries only the low flags word
    assign task_eflags = is_tss16 ?
        {{(`WR_DATA_W - `WR_TSS16_FLAGS_W){1'b0}},
         tss_image[`WR_TSS16_FLAGS_LO +: `WR_TSS16_FLAGS_W]} :
        tss_image[`WR_TSS32_EFLAGS_LO +: `WR_TSS32_EFLAGS_W];

    always_comb begin
        sels_next.es = tss_image[`WR_TSS_ES_LO +: `WR_SEL_W];
        sels_next.cs = tss_image[`WR_TSS_CS_LO +: `WR_SEL_W];
        sels_next.ss = tss_image[`WR_TSS_SS_LO +: `WR_SEL_W];
        sels_next.ds = tss_image[`WR_TSS_DS_LO +: `WR_SEL_W];
        if (is_tss16) begin
            // no fs and gs in the old layout
            sels_next.fs   = '0;
            sels_next.gs   = '0;
            sels_next.ldtr = tss_image[`WR_TSS16_LDTR_LO +: `WR_SEL_W];
        end else begin
            sels_next.fs   = tss_image[`WR_TSS32_FS_LO +: `WR_SEL_W];
            sels_next.gs   = tss_image[`WR_TSS32_GS_LO +: `WR_SEL_W];
            sels_next.ldtr = tss_image[`WR_TSS32_LDTR_LO +: `WR_SEL_W];
        end
    end

    // ------------------------------------------------------------
    // selector bank and done strobe
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg_sels  <= '0;
            task_done <= 1'b0;
        end else begin
            task_done <= task_load;
            if (task_load) begin
                seg_sels <= sels_next;
            end
        end
    end

    // one pulse per accepted task load
    assert property (@(posedge clk) disable iff (!arst_n)
        (task_done && !task_load) |=> !task_done)
        else $error("wr_task_unpack: task_done held without a new task load");

endmodule

// ==== logic/wr_eflags_reg.sv ====
`timescale 1ns/1ps
`include "wr_settings.svh"

module wr_eflags_reg (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  wr_ready,
    input  wr_pkg::wr_cmd_e       wr_cmd,
    input  wr_pkg::arith_flags_t  flags,
    input  logic                  task_load,
    input  logic [`WR_DATA_W-1:0] task_eflags,
    output logic [`WR_DATA_W-1:0] eflags
);

    logic                  take_arith;
    logic [`WR_DATA_W-1:0] eflags_arith;
    logic [`WR_DATA_W-1:0] eflags_task;
    logic [`WR_DATA_W-1:0] eflags_next;

    assign take_arith = wr_ready && (wr_cmd == wr_pkg::CMD_ARITH);

    // ------------------------------------------------------------
    // next value
    // ------------------------------------------------------------

    // arithmetic write touches only OSZAPC
    always_comb begin
        eflags_arith            = eflags;
        eflags_arith[`WR_EF_CF] = flags.cf;
        eflags_arith[`WR_EF_PF] = flags.pf;
        eflags_arith[`WR_EF_AF] = flags.af;
        eflags_arith[`WR_EF_ZF] = flags.zf;
        eflags_arith[`WR_EF_SF] = flags.sf;
        eflags_arith[`WR_EF_OF] = flags.of;
    end

    // reserved bits cleared, bit 1 forced
    assign eflags_task = (task_eflags & `WR_EF_WRITABLE) | `WR_EF_FIXED_ONE;

    always_comb begin
        if (task_load) begin
            eflags_next = eflags_task;
        end else if (take_arith) begin
            eflags_next = eflags_arith;
        end else begin
            eflags_next = eflags;
        end
    end

    // ------------------------------------------------------------
    // register
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            eflags <= `WR_EF_RESET;
        end else begin
            eflags <= eflags_next;
        end
    end

    // fixed bit survives every write path
    assert property (@(posedge clk) disable iff (!arst_n)
        (eflags & `WR_EF_FIXED_ONE) == `WR_EF_FIXED_ONE)
        else $error("wr_eflags_reg: reserved bit 1 read as zero, eflags %h", eflags);

endmodule

// ==== logic/wr_commands.sv ====
`timescale 1ns/1ps
`include "wr_settings.svh"

module wr_commands (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       wr_ready,
    input  wr_pkg::wr_cmd_e            wr_cmd,
    input  wr_pkg::arith_op_e          wr_op,
    input  wr_pkg::op_size_e           wr_size,
    input  wr_pkg::operands_t          wr_operands,
    input  wr_pkg::alu_carries_t       wr_carries,
    input  logic [3:0]                 tss_type,
    input  logic [`WR_TSS_IMAGE_W-1:0] tss_image,
    output logic [`WR_DATA_W-1:0]      eflags,
    output wr_pkg::task_sels_t         seg_sels,
    output logic                       task_done
);

    wr_pkg::arith_flags_t  arith_flags;
    logic [`WR_DATA_W-1:0] task_eflags;
    logic                  task_load;

    // ------------------------------------------------------------
    // status flags from the execute result
    // ------------------------------------------------------------

    wr_flags_calc u_flags_calc (
        .op      (wr_op),
        .size    (wr_size),
        .opnds   (wr_operands),
        .carries (wr_carries),
        .flags   (arith_flags)
    );

    // ------------------------------------------------------------
    // task switch image
    // ------------------------------------------------------------

    wr_task_unpack u_task_unpack (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_ready    (wr_ready),
        .wr_cmd      (wr_cmd),
        .tss_type    (tss_type),
        .tss_image   (tss_image),
        .task_eflags (task_eflags),
        .task_load   (task_load),
        .seg_sels    (seg_sels),
        .task_done   (task_done)
    );

    // flags register, arithmetic or task write
    wr_eflags_reg u_eflags_reg (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_ready    (wr_ready),
        .wr_cmd      (wr_cmd),
        .flags       (arith_flags),
        .task_load   (task_load),
        .task_eflags (task_eflags),
        .eflags      (eflags)
    );

endmodule

// ==== verif/tb_wr_model.svh ====
`ifndef TB_WR_MODEL_SVH
`define TB_WR_MODEL_SVH

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// or, and, xor and every index without the valid bit
function automatic logic is_logic_op(input logic [3:0] op);
    return !op[3] || op == wr_pkg::OP_OR || op == wr_pkg::OP_AND || op == wr_pkg::OP_XOR;
endfunction

function automatic wr_pkg::arith_flags_t flags_of_result(
    input logic [3:0]           op,
    input logic [1:0]           size,
    input logic [31:0]          src,
    input logic [31:0]          dst,
    input logic [31:0]          result,
    input wr_pkg::alu_carries_t c
);
    int unsigned          w;
    logic [31:0]          x;
    logic                 is_sub;
    logic                 s_src;
    logic                 s_dst;
    logic                 s_res;
    logic                 cf;
    wr_pkg::arith_flags_t f;
    w      = (size == 2'd0) ? 8 : (size == 2'd1) ? 16 : 32;
    x      = src ^ dst ^ result;
    is_sub = op == wr_pkg::OP_SBB || op == wr_pkg::OP_SUB || op == wr_pkg::OP_CMP;
    s_src  = src[w-1];
    s_dst  = dst[w-1];
    s_res  = result[w-1];
    if (w < 32) begin
        cf = x[w];
    end else if (op == wr_pkg::OP_ADD) begin
        cf = c.add_c;
    end else if (op == wr_pkg::OP_ADC) begin
        cf = c.adc_c;
    end else if (op == wr_pkg::OP_SBB) begin
        cf = c.sbb_c;
    end else begin
        cf = c.sub_c;
    end
    f.sf = s_res;
    f.zf = (result << (32 - w)) == 32'd0;
    f.pf = ($countones(result[7:0]) % 2) == 0;
    f.af = is_logic_op(op) ? 1'b0 : x[4];
    f.cf = is_logic_op(op) ? 1'b0 : cf;
    if (is_logic_op(op)) begin
        f.of = 1'b0;
    end else if (is_sub) begin
        f.of = (s_src != s_dst) && (s_res != s_dst);
    end else begin
        f.of = (s_src == s_dst) && (s_res != s_src);
    end
    return f;
endfunction

function automatic logic [31:0] merge_arith(
    input logic [31:0]          ef,
    input wr_pkg::arith_flags_t f
);
    logic [31:0] r;
    r = ef;
    r[0]  = f.cf;
    r[2]  = f.pf;
    r[4]  = f.af;
    r[6]  = f.zf;
    r[7]  = f.sf;
    r[11] = f.of;
    return r;
endfunction

// raw flags word of the image with the reserved bits cleared
function automatic logic [31:0] eflags_from_image(
    input logic [3:0]                 ty,
    input logic [`WR_TSS_IMAGE_W-1:0] img
);
    logic [31:0] ef;
    if (ty <= `WR_TSS16_MAX_TYPE) begin
        ef = {16'h0000, img[383:368]};
    end else begin
        ef = img[399:368];
    end
    // reserved bits read as zero and bit 1 reads as one
    ef[31:22] = 10'd0;
    ef[20:19] = 2'b00;
    ef[15]    = 1'b0;
    ef[5]     = 1'b0;
    ef[3]     = 1'b0;
    ef[1]     = 1'b1;
    return ef;
endfunction

function automatic wr_pkg::task_sels_t sels_from_image(
    input logic [3:0]                 ty,
    input logic [`WR_TSS_IMAGE_W-1:0] img
);
    wr_pkg::task_sels_t s;
    s.es = img[111:96];
    s.cs = img[95:80];
    s.ss = img[79:64];
    s.ds = img[63:48];
    if (ty <= `WR_TSS16_MAX_TYPE) begin
        s.fs   = 16'h0000;
        s.gs   = 16'h0000;
        s.ldtr = img[47:32];
    end else begin
        s.fs   = img[47:32];
        s.gs   = img[31:16];
        s.ldtr = img[15:0];
    end
    return s;
endfunction

`endif

// ==== verif/tb_wr_commands.sv ====
`timescale 1ns/1ps
`include "wr_settings.svh"

module tb_wr_commands;

    localparam int NUM_CMDS       = 2000;
    localparam int RESET_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = NUM_CMDS + RESET_CYCLES + 50;

    logic                       clk;
    logic                       arst_n;
    logic                       wr_ready;
    wr_pkg::wr_cmd_e            wr_cmd;
    wr_pkg::arith_op_e          wr_op;
    wr_pkg::op_size_e           wr_size;
    wr_pkg::operands_t          wr_operands;
    wr_pkg::alu_carries_t       wr_carries;
    logic [3:0]                 tss_type;
    logic [`WR_TSS_IMAGE_W-1:0] tss_image;
    logic [`WR_DATA_W-1:0]      eflags;
    wr_pkg::task_sels_t         seg_sels;
    logic                       task_done;

    logic [31:0]           lfsr_state;
    int unsigned           cycle_count;
    logic [`WR_DATA_W-1:0] model_eflags;
    wr_pkg::task_sels_t    model_sels;
    logic [`WR_DATA_W-1:0] exp_eflags_q[$];
    wr_pkg::task_sels_t    exp_sels_q[$];
    logic                  exp_done_q[$];
    logic                  prev_taken;
    int unsigned           n_arith;
    int unsigned           n_logic;
    int unsigned           n_task32;
    int unsigned           n_task16;
    int unsigned           n_b2b;

    `include "tb_wr_model.svh"

    wr_commands u_wr_commands (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_ready    (wr_ready),
        .wr_cmd      (wr_cmd),
        .wr_op       (wr_op),
        .wr_size     (wr_size),
        .wr_operands (wr_operands),
        .wr_carries  (wr_carries),
        .tss_type    (tss_type),
        .tss_image   (tss_image),
        .eflags      (eflags),
        .seg_sels    (seg_sels),
        .task_done   (task_done)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // failure reporting and watchdog
    // ------------------------------------------------------------

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("timeout, the run did not finish within the cycle limit");
        end
    end

    // ------------------------------------------------------------
    // stimulus and checks
    // ------------------------------------------------------------

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_outputs();
        logic [`WR_DATA_W-1:0] exp_e;
        wr_pkg::task_sels_t    exp_s;
        logic                  exp_d;
        if (exp_done_q.size() == 0) begin
            abort_run("no expected value was queued for this check");
        end else begin
            exp_e = exp_eflags_q.pop_front();
            exp_s = exp_sels_q.pop_front();
            exp_d = exp_done_q.pop_front();
            assert (eflags === exp_e)
                else report_mismatch("eflags", 128'(eflags), 128'(exp_e));
            assert (seg_sels === exp_s)
                else report_mismatch("seg_sels", 128'(seg_sels), 128'(exp_s));
            assert (task_done === exp_d)
                else report_mismatch("task_done", 128'(task_done), 128'(exp_d));
        end
    endtask

    task automatic drive_random();
        logic [2:0]                 pick;
        logic [1:0]                 sz;
        logic [31:0]                src;
        logic [31:0]                dst;
        logic [31:0]                res;
        logic                       cin;
        logic [32:0]                sum_add;
        logic [32:0]                sum_adc;
        logic [32:0]                dif_sub;
        logic [32:0]                dif_sbb;
        logic [`WR_TSS_IMAGE_W-1:0] img;
        logic                       taken;
        logic                       exp_d;
        wr_pkg::alu_carries_t       c;
        wr_pkg::arith_op_e          op;
        wr_pkg::op_size_e           size;
        wr_ready = rand_bits(3) != 32'd0;
        pick     = 3'(rand_bits(3));
        wr_cmd   = (pick == 3'd0) ? wr_pkg::CMD_NONE :
                   (pick >= 3'd6) ? wr_pkg::CMD_TASK_LOAD : wr_pkg::CMD_ARITH;
        op   = wr_pkg::arith_op_e'(4'(rand_bits(4)));
        sz   = 2'(rand_bits(2));
        size = (sz == 2'd3) ? wr_pkg::SIZE_32 : wr_pkg::op_size_e'(sz);
        src  = rand_bits(32);
        // equal operands now and then for zero results
        dst  = (rand_bits(3) == 32'd0) ? src : rand_bits(32);
        cin  = 1'(rand_bits(1));
        sum_add = {1'b0, dst} + {1'b0, src};
        sum_adc = {1'b0, dst} + {1'b0, src} + {32'd0, cin};
        dif_sub = {1'b0, dst} - {1'b0, src};
        dif_sbb = {1'b0, dst} - {1'b0, src} - {32'd0, cin};
        c.add_c = sum_add[32];
        c.adc_c = sum_adc[32];
        c.sub_c = dif_sub[32];
        c.sbb_c = dif_sbb[32];
        case (op)
            wr_pkg::OP_ADD: res = sum_add[31:0];
            wr_pkg::OP_ADC: res = sum_adc[31:0];
            wr_pkg::OP_SBB: res = dif_sbb[31:0];
            wr_pkg::OP_SUB: res = dif_sub[31:0];
            wr_pkg::OP_CMP: res = dif_sub[31:0];
            wr_pkg::OP_OR:  res = src | dst;
            wr_pkg::OP_AND: res = src & dst;
            wr_pkg::OP_XOR: res = src ^ dst;
            default:        res = rand_bits(32);
        endcase
        for (int k = 0; k < 12; k++) begin
            img[k*32 +: 32] = rand_bits(32);
        end
        img[399:384] = 16'(rand_bits(16));
        wr_op              = op;
        wr_size            = size;
        wr_operands.src    = src;
        wr_operands.dst    = dst;
        wr_operands.result = res;
        wr_carries         = c;
        tss_type           = 4'(rand_bits(4));
        tss_image          = img;

        // model of the write stage
        taken = wr_ready && wr_cmd != wr_pkg::CMD_NONE;
        if (taken && prev_taken) begin
            n_b2b++;
        end
        prev_taken = taken;
        exp_d = 1'b0;
        if (wr_ready && wr_cmd == wr_pkg::CMD_TASK_LOAD) begin
            model_eflags = eflags_from_image(tss_type, img);
            model_sels   = sels_from_image(tss_type, img);
            exp_d        = 1'b1;
            if (tss_type <= `WR_TSS16_MAX_TYPE) begin
                n_task16++;
            end else begin
                n_task32++;
            end
        end else if (wr_ready && wr_cmd == wr_pkg::CMD_ARITH) begin
            model_eflags = merge_arith(model_eflags, flags_of_result(op, sz == 2'd3 ?
                                       2'd2 : sz, src, dst, res, c));
            if (is_logic_op(op)) begin
                n_logic++;
            end else begin
                n_arith++;
            end
        end
        exp_eflags_q.push_back(model_eflags);
        exp_sels_q.push_back(model_sels);
        exp_done_q.push_back(exp_d);
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        wr_ready     = 1'b0;
        wr_cmd       = wr_pkg::CMD_NONE;
        wr_op        = wr_pkg::OP_ADD;
        wr_size      = wr_pkg::SIZE_8;
        wr_operands  = '0;
        wr_carries   = '0;
        tss_type     = 4'd0;
        tss_image    = '0;
        lfsr_state   = 32'h7c86;
        cycle_count  = 0;
        model_eflags = `WR_EF_RESET;
        model_sels   = '0;
        prev_taken   = 1'b0;
        n_arith      = 0;
        n_logic      = 0;
        n_task32     = 0;
        n_task16     = 0;
        n_b2b        = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // first check sees the reset values
        exp_eflags_q.push_back(`WR_EF_RESET);
        exp_sels_q.push_back('0);
        exp_done_q.push_back(1'b0);
        for (int i = 0; i < NUM_CMDS; i++) begin
            @(negedge clk);
            check_outputs();
            drive_random();
        end
        @(negedge clk);
        check_outputs();
        if (n_arith > 0 && n_logic > 0 && n_task32 > 0 && n_task16 > 0 && n_b2b > 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("random stimulus did not reach every kind of command");
        end
    end

endmodule

// ==== vlog.f ====
+incdir+logic
+incdir+verif
logic/wr_pkg.sv
logic/wr_flags_calc.sv
logic/wr_task_unpack.sv
logic/wr_eflags_reg.sv
logic/wr_commands.sv
verif/tb_wr_commands.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal -f vlog.f \
    --top-module tb_wr_commands -o sim_wr_commands

sim_status=0
./obj_dir/sim_wr_commands > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if [ "$sim_status" -ne 0 ] || ! grep -q "STATUS: PASS" sim.log; then
    exit 1
fi
